// File: Bender.yml
package:
  name: mips_instr_decode

sources:
  - include_dirs:
      - design
    files:
      - design/mips_decode_pkg.sv
      - design/decode_buses.sv
      - design/ctrl_decoder.sv
      - design/flow_decoder.sv
      - design/decode_out_reg.sv
      - design/instr_decode_top.sv
  - target: test
    include_dirs:
      - design
      - tests
    files:
      - tests/tb_instr_decode.sv

// File: design/ctrl_decoder.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module ctrl_decoder (
    input  logic [`MIPS_XLEN-1:0] instr,
    ctrl_bus_if.src               ctrl
);
    import mips_decode_pkg::*;

    opcode_e op;
    funct_e  funct;
    regimm_e rt_code;

    assign op      = opcode_e'(instr[31:26]);
    assign funct   = funct_e'(instr[5:0]);
    assign rt_code = regimm_e'(instr[20:16]);

    // alu operation, NOP for anything without one
    always_comb begin
        ctrl.alu_op = ALU_NOP;
        case (op)
            OP_SPECIAL: begin
                case (funct)
                    FN_AND:   ctrl.alu_op = ALU_AND;
                    FN_OR:    ctrl.alu_op = ALU_OR;
                    FN_XOR:   ctrl.alu_op = ALU_XOR;
                    FN_NOR:   ctrl.alu_op = ALU_NOR;
                    FN_SLT:   ctrl.alu_op = ALU_SLT;
                    FN_SLTU:  ctrl.alu_op = ALU_SLTU;
                    FN_ADD:   ctrl.alu_op = ALU_ADD;
                    FN_ADDU:  ctrl.alu_op = ALU_ADDU;
                    FN_SUB:   ctrl.alu_op = ALU_SUB;
                    FN_SUBU:  ctrl.alu_op = ALU_SUBU;
                    FN_SLL:   ctrl.alu_op = ALU_SLL;
                    FN_SLLV:  ctrl.alu_op = ALU_SLLV;
                    FN_SRL:   ctrl.alu_op = ALU_SRL;
                    FN_SRLV:  ctrl.alu_op = ALU_SRLV;
                    FN_SRA:   ctrl.alu_op = ALU_SRA;
                    FN_SRAV:  ctrl.alu_op = ALU_SRAV;
                    FN_MULT:  ctrl.alu_op = ALU_MULT;
                    FN_MULTU: ctrl.alu_op = ALU_MULTU;
                    FN_DIV:   ctrl.alu_op = ALU_DIV;
                    FN_DIVU:  ctrl.alu_op = ALU_DIVU;
                    FN_MFHI:  ctrl.alu_op = ALU_MFHI;
                    FN_MFLO:  ctrl.alu_op = ALU_MFLO;
                    FN_MTHI:  ctrl.alu_op = ALU_MTHI;
                    FN_MTLO:  ctrl.alu_op = ALU_MTLO;
                    default:  ctrl.alu_op = ALU_NOP;
                endcase
            end
            OP_ADDI:  ctrl.alu_op = ALU_ADD;
            OP_ADDIU: ctrl.alu_op = ALU_ADDU;
            OP_SLTI:  ctrl.alu_op = ALU_SLT;
            OP_SLTIU: ctrl.alu_op = ALU_SLTU;
            OP_ANDI:  ctrl.alu_op = ALU_AND;
            OP_ORI:   ctrl.alu_op = ALU_OR;
            OP_XORI:  ctrl.alu_op = ALU_XOR;
            OP_LUI:   ctrl.alu_op = ALU_LUI;
            default:  ctrl.alu_op = ALU_NOP;
        endcase
    end

    always_comb begin
        ctrl.read_rs         = 1'b0;
        ctrl.read_rt         = 1'b0;
        ctrl.reg_write       = 1'b0;
        ctrl.mem_read        = 1'b0;
        ctrl.mem_write       = 1'b0;
        ctrl.hilo_read       = 1'b0;
        ctrl.hilo_write      = 1'b0;
        ctrl.may_bring_flush = 1'b0;
        ctrl.syscall_inst    = 1'b0;
        ctrl.break_inst      = 1'b0;
        ctrl.undefined_inst  = 1'b0;
        case (op)
            OP_SPECIAL: begin
                case (funct)
                    FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_ADD, FN_ADDU,
                    FN_SUB, FN_SUBU, FN_SLLV, FN_SRLV, FN_SRAV: begin
                        ctrl.read_rs   = 1'b1;
                        ctrl.read_rt   = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    FN_SLL, FN_SRL, FN_SRA: begin // shift by shamt
                        ctrl.read_rt   = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                        ctrl.read_rs    = 1'b1;
                        ctrl.read_rt    = 1'b1;
                        ctrl.hilo_write = 1'b1;
                    end
                    FN_MFHI, FN_MFLO: begin
                        ctrl.hilo_read = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    FN_MTHI, FN_MTLO: begin
                        ctrl.read_rs    = 1'b1;
                        ctrl.hilo_write = 1'b1;
                    end
                    FN_JR, FN_JALR: begin
                        ctrl.read_rs         = 1'b1;
                        ctrl.may_bring_flush = 1'b1;
                        ctrl.reg_write       = (funct == FN_JALR); // rd = pc+8
                    end
                    FN_SYSCALL: begin
                        ctrl.syscall_inst    = 1'b1;
                        ctrl.may_bring_flush = 1'b1;
                    end
                    FN_BREAK: begin
                        ctrl.break_inst      = 1'b1;
                        ctrl.may_bring_flush = 1'b1;
                    end
                    default: ctrl.undefined_inst = 1'b1;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.read_rs   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                ctrl.read_rs   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl.read_rs   = 1'b1;
                ctrl.read_rt   = 1'b1; // store data
                ctrl.mem_write = 1'b1;
            end
            OP_J, OP_JAL: begin
                ctrl.may_bring_flush = 1'b1;
                ctrl.reg_write       = (op == OP_JAL);
            end
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
                ctrl.read_rs         = 1'b1;
                ctrl.read_rt         = 1'b1;
                ctrl.may_bring_flush = 1'b1;
            end
            OP_REGIMM: begin
                case (rt_code)
                    RT_BGEZ, RT_BLTZ, RT_BGEZAL, RT_BLTZAL: begin
                        ctrl.read_rs         = 1'b1; // rt is the sub-opcode here
                        ctrl.may_bring_flush = 1'b1;
                        ctrl.reg_write       = rt_code inside {RT_BGEZAL, RT_BLTZAL};
                    end
                    default: ctrl.undefined_inst = 1'b1;
                endcase
            end
            default: ctrl.undefined_inst = 1'b1;
        endcase
    end

endmodule

// File: design/decode_buses.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

interface ctrl_bus_if;
    import mips_decode_pkg::*;

    alu_op_e alu_op;
    logic    read_rs;
    logic    read_rt;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    hilo_read;
    logic    hilo_write;
    logic    may_bring_flush;
    logic    syscall_inst;
    logic    break_inst;
    logic    undefined_inst;

    modport src (
        output alu_op, read_rs, read_rt, reg_write, mem_read, mem_write,
               hilo_read, hilo_write, may_bring_flush,
               syscall_inst, break_inst, undefined_inst
    );
    modport dst (
        input  alu_op, read_rs, read_rt, reg_write, mem_read, mem_write,
               hilo_read, hilo_write, may_bring_flush,
               syscall_inst, break_inst, undefined_inst
    );
endinterface

interface flow_bus_if;
    import mips_decode_pkg::*;

    branch_type_e                branch_type;
    logic                        is_link;     // pc+8 goes to reg_waddr
    logic [`MIPS_REG_ADDR_W-1:0] reg_waddr;
    logic [`MIPS_XLEN-1:0]       imm_ext;

    modport src (output branch_type, is_link, reg_waddr, imm_ext);
    modport dst (input  branch_type, is_link, reg_waddr, imm_ext);
endinterface

// File: design/decode_out_reg.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module decode_out_reg (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [`MIPS_REG_ADDR_W-1:0]        rs,
    input  logic [`MIPS_REG_ADDR_W-1:0]        rt,
    input  logic [`MIPS_SHAMT_W-1:0]           shamt,
    ctrl_bus_if.dst                            ctrl,
    flow_bus_if.dst                            flow,
    output logic                               out_valid,
    input  logic                               out_ready,
    output mips_decode_pkg::alu_op_e           alu_op,
    output logic                               read_rs,
    output logic                               read_rt,
    output logic                               reg_write,
    output logic [`MIPS_REG_ADDR_W-1:0]        reg_waddr,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic                               hilo_read,
    output logic                               hilo_write,
    output logic                               may_bring_flush,
    output mips_decode_pkg::branch_type_e      branch_type,
    output logic                               is_link,
    output logic                               syscall_inst,
    output logic                               break_inst,
    output logic                               undefined_inst,
    output logic [`MIPS_REG_ADDR_W-1:0]        rs_q,
    output logic [`MIPS_REG_ADDR_W-1:0]        rt_q,
    output logic [`MIPS_SHAMT_W-1:0]           shamt_q,
    output logic [`MIPS_XLEN-1:0]              imm_ext
);

    logic accept;

    assign in_ready = ~out_valid | out_ready; // empty, or drained this cycle
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op          <= ctrl.alu_op;
            read_rs         <= ctrl.read_rs;
            read_rt         <= ctrl.read_rt;
            reg_write       <= ctrl.reg_write;
            mem_read        <= ctrl.mem_read;
            mem_write       <= ctrl.mem_write;
            hilo_read       <= ctrl.hilo_read;
            hilo_write      <= ctrl.hilo_write;
            may_bring_flush <= ctrl.may_bring_flush;
            syscall_inst    <= ctrl.syscall_inst;
            break_inst      <= ctrl.break_inst;
            undefined_inst  <= ctrl.undefined_inst;
            branch_type     <= flow.branch_type;
            is_link         <= flow.is_link;
            reg_waddr       <= flow.reg_waddr;
            imm_ext         <= flow.imm_ext;
            rs_q            <= rs;
            rt_q            <= rt;
            shamt_q         <= shamt;
        end
    end

endmodule

// File: design/flow_decoder.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module flow_decoder (
    input  logic [`MIPS_XLEN-1:0] instr,
    flow_bus_if.src               flow
);
    import mips_decode_pkg::*;

    opcode_e                     op;
    funct_e                      funct;
    regimm_e                     rt_code;
    logic [`MIPS_REG_ADDR_W-1:0] rt;
    logic [`MIPS_REG_ADDR_W-1:0] rd;
    logic [`MIPS_IMM_W-1:0]      imm;

    assign op      = opcode_e'(instr[31:26]);
    assign funct   = funct_e'(instr[5:0]);
    assign rt_code = regimm_e'(instr[20:16]);
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign imm     = instr[15:0];

    always_comb begin
        flow.branch_type = BT_NONE;
        flow.is_link     = 1'b0;
        case (op)
            OP_SPECIAL: begin
                if (funct inside {FN_JR, FN_JALR}) begin
                    flow.branch_type = BT_JREG;
                    flow.is_link     = (funct == FN_JALR);
                end
            end
            OP_J:    flow.branch_type = BT_J;
            OP_JAL: begin
                flow.branch_type = BT_J;
                flow.is_link     = 1'b1;
            end
            OP_BEQ:  flow.branch_type = BT_BEQ;
            OP_BNE:  flow.branch_type = BT_BNE;
            OP_BGTZ: flow.branch_type = BT_BGTZ;
            OP_BLEZ: flow.branch_type = BT_BLEZ;
            OP_REGIMM: begin
                case (rt_code)
                    RT_BGEZ, RT_BGEZAL: flow.branch_type = BT_BGEZ;
                    RT_BLTZ, RT_BLTZAL: flow.branch_type = BT_BLTZ;
                    default:            flow.branch_type = BT_NONE;
                endcase
                flow.is_link = rt_code inside {RT_BGEZAL, RT_BLTZAL};
            end
            default: flow.branch_type = BT_NONE;
        endcase
    end

    always_comb begin
        flow.reg_waddr = rd;
        if (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_ADDI, OP_ADDIU, OP_SLTI,
                       OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
            flow.reg_waddr = rt;
        else if (op == OP_JAL || (op == OP_REGIMM && rt_code inside {RT_BGEZAL, RT_BLTZAL}))
            flow.reg_waddr = `MIPS_LINK_REG;
    end

    // logic immediates are unsigned
    assign flow.imm_ext = (op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
                        ? {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, imm}
                        : {{(`MIPS_XLEN-`MIPS_IMM_W){imm[`MIPS_IMM_W-1]}}, imm};

endmodule

// File: design/instr_decode_top.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module instr_decode_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [`MIPS_XLEN-1:0]         instr,
    output logic                          out_valid,
    input  logic                          out_ready,
    output mips_decode_pkg::alu_op_e      alu_op,
    output logic                          read_rs,
    output logic                          read_rt,
    output logic                          reg_write,
    output logic [`MIPS_REG_ADDR_W-1:0]   reg_waddr,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          hilo_read,
    output logic                          hilo_write,
    output logic                          may_bring_flush,
    output mips_decode_pkg::branch_type_e branch_type,
    output logic                          is_link,
    output logic                          syscall_inst,
    output logic                          break_inst,
    output logic                          undefined_inst,
    output logic [`MIPS_REG_ADDR_W-1:0]   rs,
    output logic [`MIPS_REG_ADDR_W-1:0]   rt,
    output logic [`MIPS_SHAMT_W-1:0]      shamt,
    output logic [`MIPS_XLEN-1:0]         imm_ext
);

    ctrl_bus_if ctrl_bus ();
    flow_bus_if flow_bus ();

    ctrl_decoder u_ctrl_decoder (.instr(instr), .ctrl(ctrl_bus.src));

    flow_decoder u_flow_decoder (.instr(instr), .flow(flow_bus.src));

    decode_out_reg u_decode_out_reg (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .rs             (instr[25:21]),
        .rt             (instr[20:16]),
        .shamt          (instr[10:6]),
        .ctrl           (ctrl_bus.dst),
        .flow           (flow_bus.dst),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .alu_op         (alu_op),
        .read_rs        (read_rs),
        .read_rt        (read_rt),
        .reg_write      (reg_write),
        .reg_waddr      (reg_waddr),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .hilo_read      (hilo_read),
        .hilo_write     (hilo_write),
        .may_bring_flush(may_bring_flush),
        .branch_type    (branch_type),
        .is_link        (is_link),
        .syscall_inst   (syscall_inst),
        .break_inst     (break_inst),
        .undefined_inst (undefined_inst),
        .rs_q           (rs),
        .rt_q           (rt),
        .shamt_q        (shamt),
        .imm_ext        (imm_ext)
    );

endmodule

// File: design/mips_decode_pkg.sv
`include "mips_settings.svh"

package mips_decode_pkg;

    // primary opcode, instr[31:26]
    typedef enum logic [`MIPS_OP_W-1:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
        OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
    } opcode_e;

    // SPECIAL function field, instr[5:0]
    typedef enum logic [`MIPS_FUNCT_W-1:0] {
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_SRA     = 6'h03,
        FN_SLLV    = 6'h04,
        FN_SRLV    = 6'h06,
        FN_SRAV    = 6'h07,
        FN_JR      = 6'h08,
        FN_JALR    = 6'h09,
        FN_SYSCALL = 6'h0c,
        FN_BREAK   = 6'h0d,
        FN_MFHI    = 6'h10,
        FN_MTHI    = 6'h11,
        FN_MFLO    = 6'h12,
        FN_MTLO    = 6'h13,
        FN_MULT    = 6'h18,
        FN_MULTU   = 6'h19,
        FN_DIV     = 6'h1a,
        FN_DIVU    = 6'h1b,
        FN_ADD     = 6'h20,
        FN_ADDU    = 6'h21,
        FN_SUB     = 6'h22,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_NOR     = 6'h27,
        FN_SLT     = 6'h2a,
        FN_SLTU    = 6'h2b
    } funct_e;

    // REGIMM rt field
    typedef enum logic [`MIPS_REG_ADDR_W-1:0] {
        RT_BLTZ   = 5'h00,
        RT_BGEZ   = 5'h01,
        RT_BLTZAL = 5'h10,
        RT_BGEZAL = 5'h11
    } regimm_e;

    typedef enum logic [`MIPS_ALU_OP_W-1:0] {
        ALU_NOP,  ALU_AND,  ALU_OR,    ALU_XOR,  ALU_NOR,
        ALU_SLT,  ALU_SLTU, ALU_ADD,   ALU_ADDU, ALU_SUB,
        ALU_SUBU, ALU_SLL,  ALU_SLLV,  ALU_SRL,  ALU_SRLV,
        ALU_SRA,  ALU_SRAV, ALU_MULT,  ALU_MULTU, ALU_DIV,
        ALU_DIVU, ALU_MFHI, ALU_MFLO,  ALU_MTHI, ALU_MTLO,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BT_NONE,
        BT_JREG,   // target from rs
        BT_J,      // 26 bit region jump
        BT_BEQ,
        BT_BNE,
        BT_BGTZ,
        BT_BLEZ,
        BT_BGEZ,
        BT_BLTZ
    } branch_type_e;

endpackage

// File: design/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// instruction and data word
`define MIPS_XLEN        32

// instruction field widths
`define MIPS_OP_W        6
`define MIPS_FUNCT_W     6
`define MIPS_REG_ADDR_W  5
`define MIPS_SHAMT_W     5
`define MIPS_IMM_W       16

// GPR[31] takes pc+8 on JAL, BGEZAL, BLTZAL
`define MIPS_LINK_REG    5'd31

// width of the alu operation code
`define MIPS_ALU_OP_W    8

`endif

// File: list.f
+incdir+design
+incdir+tests
design/mips_decode_pkg.sv
design/decode_buses.sv
design/ctrl_decoder.sv
design/flow_decoder.sv
design/decode_out_reg.sv
design/instr_decode_top.sv
tests/tb_instr_decode.sv

// File: tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int K_ALU  = 0;
localparam int K_MEM  = 1;
localparam int K_FLOW = 2;
localparam int K_EXC  = 3;
localparam int K_MIX  = 4;

// r-type alu and shift functs, then hi/lo functs
localparam logic [16*6-1:0] ALU_FNS  = {6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                        6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
localparam logic [8*6-1:0]  HILO_FNS = {6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b};
localparam logic [8*6-1:0]  MEM_OPS  = {6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
// cop0, special2, lwl, cache etc.
localparam logic [8*6-1:0]  BAD_OPS  = {6'h10, 6'h11, 6'h1c, 6'h22, 6'h2f, 6'h3f, 6'h12, 6'h30};
localparam logic [8*6-1:0]  BAD_FNS  = {6'h01, 6'h05, 6'h0a, 6'h0b, 6'h0f, 6'h1c, 6'h34, 6'h3f};
localparam logic [4*5-1:0]  BAD_RTS  = {5'h02, 5'h08, 5'h0c, 5'h1f}; // traps and reserved

typedef struct packed {
    logic [`MIPS_ALU_OP_W-1:0]   alu_op;
    logic                        read_rs;
    logic                        read_rt;
    logic                        reg_write;
    logic [`MIPS_REG_ADDR_W-1:0] reg_waddr;
    logic                        mem_read;
    logic                        mem_write;
    logic                        hilo_read;
    logic                        hilo_write;
    logic                        may_bring_flush;
    logic [3:0]                  branch_type;
    logic                        is_link;
    logic                        syscall_inst;
    logic                        break_inst;
    logic                        undefined_inst;
    logic [`MIPS_REG_ADDR_W-1:0] rs;
    logic [`MIPS_REG_ADDR_W-1:0] rt;
    logic [`MIPS_SHAMT_W-1:0]    shamt;
    logic [`MIPS_XLEN-1:0]       imm_ext;
} exp_t;

logic [31:0] rng_state = 32'h9c59_8b68;

function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic exp_t ref_decode(input logic [31:0] w);
    exp_t       e;
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rtc;
    logic [6:0] key;
    op  = w[31:26];
    fn  = w[5:0];
    rtc = w[20:16];
    key = (op == 6'h00) ? {1'b1, fn} : {1'b0, op};
    e = '0;
    e.rs        = w[25:21];
    e.rt        = w[20:16];
    e.shamt     = w[10:6];
    e.reg_waddr = w[15:11];
    e.imm_ext   = (op inside {[6'h0c:6'h0f]}) ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
    case (key)
        {1'b1, 6'h20}, {1'b0, 6'h08}: e.alu_op = ALU_ADD;
        {1'b1, 6'h21}, {1'b0, 6'h09}: e.alu_op = ALU_ADDU;
        {1'b1, 6'h2a}, {1'b0, 6'h0a}: e.alu_op = ALU_SLT;
        {1'b1, 6'h2b}, {1'b0, 6'h0b}: e.alu_op = ALU_SLTU;
        {1'b1, 6'h24}, {1'b0, 6'h0c}: e.alu_op = ALU_AND;
        {1'b1, 6'h25}, {1'b0, 6'h0d}: e.alu_op = ALU_OR;
        {1'b1, 6'h26}, {1'b0, 6'h0e}: e.alu_op = ALU_XOR;
        {1'b0, 6'h0f}: e.alu_op = ALU_LUI;
        {1'b1, 6'h22}: e.alu_op = ALU_SUB;
        {1'b1, 6'h23}: e.alu_op = ALU_SUBU;
        {1'b1, 6'h27}: e.alu_op = ALU_NOR;
        {1'b1, 6'h00}: e.alu_op = ALU_SLL;
        {1'b1, 6'h02}: e.alu_op = ALU_SRL;
        {1'b1, 6'h03}: e.alu_op = ALU_SRA;
        {1'b1, 6'h04}: e.alu_op = ALU_SLLV;
        {1'b1, 6'h06}: e.alu_op = ALU_SRLV;
        {1'b1, 6'h07}: e.alu_op = ALU_SRAV;
        {1'b1, 6'h10}: e.alu_op = ALU_MFHI;
        {1'b1, 6'h11}: e.alu_op = ALU_MTHI;
        {1'b1, 6'h12}: e.alu_op = ALU_MFLO;
        {1'b1, 6'h13}: e.alu_op = ALU_MTLO;
        {1'b1, 6'h18}: e.alu_op = ALU_MULT;
        {1'b1, 6'h19}: e.alu_op = ALU_MULTU;
        {1'b1, 6'h1a}: e.alu_op = ALU_DIV;
        {1'b1, 6'h1b}: e.alu_op = ALU_DIVU;
        default:       e.alu_op = ALU_NOP;
    endcase
    if (op == 6'h00) begin
        if (fn inside {[6'h20:6'h27], 6'h2a, 6'h2b, 6'h04, 6'h06, 6'h07})
            {e.read_rs, e.read_rt, e.reg_write} = 3'b111;
        else if (fn inside {6'h00, 6'h02, 6'h03})
            {e.read_rt, e.reg_write} = 2'b11;
        else if (fn inside {[6'h18:6'h1b]})
            {e.read_rs, e.read_rt, e.hilo_write} = 3'b111;
        else if (fn inside {6'h10, 6'h12})
            {e.hilo_read, e.reg_write} = 2'b11;
        else if (fn inside {6'h11, 6'h13})
            {e.read_rs, e.hilo_write} = 2'b11;
        else if (fn inside {6'h08, 6'h09}) begin
            {e.read_rs, e.may_bring_flush} = 2'b11;
            e.branch_type = BT_JREG;
            e.is_link     = fn[0]; // jalr
            e.reg_write   = fn[0];
        end
        else if (fn == 6'h0c)
            {e.syscall_inst, e.may_bring_flush} = 2'b11;
        else if (fn == 6'h0d)
            {e.break_inst, e.may_bring_flush} = 2'b11;
        else
            e.undefined_inst = 1'b1;
    end else if (op inside {[6'h08:6'h0f], 6'h20, 6'h21, 6'h23, 6'h24, 6'h25}) begin
        {e.read_rs, e.reg_write} = 2'b11;
        e.mem_read  = op[5];
        e.reg_waddr = w[20:16];
    end else if (op inside {6'h28, 6'h29, 6'h2b}) begin
        {e.read_rs, e.read_rt, e.mem_write} = 3'b111;
    end else if (op inside {6'h02, 6'h03}) begin
        e.may_bring_flush = 1'b1;
        e.branch_type     = BT_J;
        e.is_link         = op[0];
        e.reg_write       = op[0];
        if (op[0])
            e.reg_waddr = 5'd31;
    end else if (op inside {[6'h04:6'h07]}) begin
        {e.read_rs, e.read_rt, e.may_bring_flush} = 3'b111;
        case (op[1:0])
            2'd0:    e.branch_type = BT_BEQ;
            2'd1:    e.branch_type = BT_BNE;
            2'd2:    e.branch_type = BT_BLEZ;
            default: e.branch_type = BT_BGTZ;
        endcase
    end else if (op == 6'h01 && rtc inside {5'h00, 5'h01, 5'h10, 5'h11}) begin
        {e.read_rs, e.may_bring_flush} = 2'b11;
        e.branch_type = rtc[0] ? BT_BGEZ : BT_BLTZ;
        e.is_link     = rtc[4];
        e.reg_write   = rtc[4];
        if (rtc[4])
            e.reg_waddr = 5'd31;
    end else begin
        e.undefined_inst = 1'b1;
    end
    return e;
endfunction

// random fields, then the class fields forced
function automatic logic [31:0] next_instr(input int kind);
    logic [31:0] w;
    logic [31:0] r;
    int          k;
    w = xorshift();
    r = xorshift();
    k = (kind == K_MIX) ? int'(r[31:30]) : kind;
    case (k)
        K_ALU: begin
            w[31:26] = (r[1:0] == 2'd3) ? {3'b001, r[10:8]} : 6'h00;
            w[5:0]   = r[0] ? ALU_FNS[r[7:4]*6 +: 6] : HILO_FNS[r[6:4]*6 +: 6];
        end
        K_MEM:
            w[31:26] = MEM_OPS[r[6:4]*6 +: 6];
        K_FLOW: begin
            case (r[1:0])
                2'd0:    w[31:26] = 6'h02 + 6'(r[7:4] % 6);
                2'd1:    {w[31:26], w[5:0]} = {6'h00, 5'b00010, r[4]};
                default: {w[31:26], w[20:16]} = {6'h01, r[5], 3'b000, r[4]};
            endcase
        end
        default: begin
            case (r[1:0])
                2'd0:    {w[31:26], w[5:0]} = {6'h00, 5'b00110, r[4]}; // syscall, break
                2'd1:    w[31:26] = BAD_OPS[r[6:4]*6 +: 6];
                2'd2:    {w[31:26], w[5:0]} = {6'h00, BAD_FNS[r[6:4]*6 +: 6]};
                default: {w[31:26], w[20:16]} = {6'h01, BAD_RTS[r[5:4]*5 +: 5]};
            endcase
        end
    endcase
    return w;
endfunction

`endif

// File: tests/tb_instr_decode.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_instr_decode;
    import mips_decode_pkg::*;

    `include "tb_ref_model.svh"

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_WORDS      = 200;
    localparam int TOTAL_WORDS  = 5 * N_WORDS;
    localparam int TIMEOUT_NS   = CLK_PERIOD * TOTAL_WORDS * 4 + CLK_PERIOD * RESET_CYCLES;

    logic                        clk;
    logic                        arst_n;
    logic                        in_valid;
    logic                        in_ready;
    logic [`MIPS_XLEN-1:0]       instr;
    logic                        out_valid;
    logic                        out_ready;
    alu_op_e                     alu_op;
    logic                        read_rs;
    logic                        read_rt;
    logic                        reg_write;
    logic [`MIPS_REG_ADDR_W-1:0] reg_waddr;
    logic                        mem_read;
    logic                        mem_write;
    logic                        hilo_read;
    logic                        hilo_write;
    logic                        may_bring_flush;
    branch_type_e                branch_type;
    logic                        is_link;
    logic                        syscall_inst;
    logic                        break_inst;
    logic                        undefined_inst;
    logic [`MIPS_REG_ADDR_W-1:0] rs;
    logic [`MIPS_REG_ADDR_W-1:0] rt;
    logic [`MIPS_SHAMT_W-1:0]    shamt;
    logic [`MIPS_XLEN-1:0]       imm_ext;

    logic [31:0] exp_q[$];      // accepted words, oldest first
    bit          accepted_last;
    int          pass_count = 0;
    int          fail_count = 0;

    instr_decode_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_field(input string name, input logic [31:0] got_v,
                               input logic [31:0] exp_v);
        assert (got_v === exp_v) pass_count++;
        else begin
            fail_count++;
            $display("ERROR %0t: %s is %0h, expected %0h", $time, name, got_v, exp_v);
        end
    endtask

    always @(posedge clk) begin : compare
        exp_t e;
        if (arst_n) begin
            if (accepted_last)
                check_field("out_valid one cycle after accept", out_valid, 1'b1);
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0)
                else begin
                    fail_count++;
                    $display("an output word came out with no accepted word waiting at %0t",
                             $time);
                end
                if (exp_q.size() != 0) begin
                    e = ref_decode(exp_q.pop_front());
                    check_field("alu_op", alu_op, e.alu_op);
                    check_field("read_rs", read_rs, e.read_rs);
                    check_field("read_rt", read_rt, e.read_rt);
                    check_field("reg_write", reg_write, e.reg_write);
                    check_field("reg_waddr", reg_waddr, e.reg_waddr);
                    check_field("mem_read", mem_read, e.mem_read);
                    check_field("mem_write", mem_write, e.mem_write);
                    check_field("hilo_read", hilo_read, e.hilo_read);
                    check_field("hilo_write", hilo_write, e.hilo_write);
                    check_field("may_bring_flush", may_bring_flush, e.may_bring_flush);
                    check_field("branch_type", branch_type, e.branch_type);
                    check_field("is_link", is_link, e.is_link);
                    check_field("syscall_inst", syscall_inst, e.syscall_inst);
                    check_field("break_inst", break_inst, e.break_inst);
                    check_field("undefined_inst", undefined_inst, e.undefined_inst);
                    check_field("rs", rs, e.rs);
                    check_field("rt", rt, e.rt);
                    check_field("shamt", shamt, e.shamt);
                    check_field("imm_ext", imm_ext, e.imm_ext);
                end
            end
            accepted_last = in_valid && in_ready;
            if (accepted_last)
                exp_q.push_back(instr);
        end
    end

    // starts and ends on a rising edge
    task automatic run_words(input string name, input int n, input int kind, input bit bp);
        int          sent;
        int          fails_at_start;
        logic [31:0] r;
        sent           = 0;
        fails_at_start = fail_count;
        r              = xorshift();
        in_valid  <= 1'b1;
        instr     <= next_instr(kind);
        out_ready <= bp ? r[9] : 1'b1;
        while (sent < n) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                sent++;
                if (sent < n)
                    instr <= next_instr(kind);
                else
                    in_valid <= 1'b0;
            end
            r = xorshift();
            out_ready <= bp ? r[9] : 1'b1;
        end
        out_ready <= 1'b1;
        @(negedge clk);
        while (exp_q.size() != 0 || out_valid)
            @(negedge clk);
        @(posedge clk);
        $display("test %s: %0d words, %0d failures", name, n, fail_count - fails_at_start);
    endtask

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        instr     = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_field("out_valid in reset", out_valid, 1'b0);
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_field("out_valid after reset", out_valid, 1'b0);
        check_field("in_ready after reset", in_ready, 1'b1);
        $display("test reset: %0d failures", fail_count);
        @(posedge clk);
        run_words("alu, hi/lo and immediate", N_WORDS, K_ALU, 1'b0);
        run_words("loads and stores", N_WORDS, K_MEM, 1'b0);
        run_words("jumps and branches", N_WORDS, K_FLOW, 1'b0);
        run_words("exception flags", N_WORDS, K_EXC, 1'b0);
        run_words("back-pressure", N_WORDS, K_MIX, 1'b1);
        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("the run timed out after %0d ns before all words came out", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule
